// ==== hdl/video_pkg.sv ====
`default_nettype none

package video_pkg;

    // one stored frame-buffer pixel, 5:6:5
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // widened pixel, 8 bits per color
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

    // one encoded 10-bit channel word
    typedef logic [9:0] tmds_word_t;

    // bit 0 hsync, bit 1 vsync
    typedef logic [1:0] ctrl_t;

    // control words sent during blanking, indexed by {vsync, hsync}
    localparam tmds_word_t CTRL_CODE_00 = 10'b1101010100;
    localparam tmds_word_t CTRL_CODE_01 = 10'b0010101011;
    localparam tmds_word_t CTRL_CODE_10 = 10'b0101010100;
    localparam tmds_word_t CTRL_CODE_11 = 10'b1010101011;

    // reduced raster, horizontal in pixels
    localparam int DEF_H_ACTIVE = 40;
    localparam int DEF_H_FRONT  = 4;
    localparam int DEF_H_SYNC   = 6;
    localparam int DEF_H_BACK   = 6;

    // vertical in lines
    localparam int DEF_V_ACTIVE = 20;
    localparam int DEF_V_FRONT  = 2;
    localparam int DEF_V_SYNC   = 2;
    localparam int DEF_V_BACK   = 2;

    // frame-buffer window in the top left corner, 512 pixels
    localparam int DEF_FB_WIDTH  = 32;
    localparam int DEF_FB_HEIGHT = 16;

endpackage

`default_nettype wire

// ==== hdl/fb_port_if.sv ====
`default_nettype none

// bus-side frame-buffer port, no handshake
interface fb_port_if #(
    parameter int ADDR_W = 9
);
    logic               wr_en;
    logic               rd_en;
    logic [ADDR_W-1:0]  addr;
    video_pkg::rgb565_t wr_data;
    // valid one cycle after rd_en
    video_pkg::rgb565_t rd_data;

    modport bus (output wr_en, output rd_en, output addr, output wr_data, input rd_data);
    modport mem (input wr_en, input rd_en, input addr, input wr_data, output rd_data);
endinterface

`default_nettype wire

// ==== hdl/video_beat_if.sv ====
`default_nettype none

// one display beat, all fields for the same raster position
interface video_beat_if;
    logic               active;
    logic               h_sync;
    logic               v_sync;
    // black outside the frame-buffer window
    video_pkg::rgb888_t pixel;

    modport source (output active, output h_sync, output v_sync, output pixel);
    modport sink (input active, input h_sync, input v_sync, input pixel);
endinterface

`default_nettype wire

// ==== hdl/apb_fb_port.sv ====
`default_nettype none

module apb_fb_port #(
    parameter int FB_WIDTH  = video_pkg::DEF_FB_WIDTH,
    parameter int FB_HEIGHT = video_pkg::DEF_FB_HEIGHT,
    localparam int FB_DEPTH = FB_WIDTH * FB_HEIGHT,
    localparam int AW       = $clog2(FB_DEPTH)
) (
    input wire          clk_pixel,
    input wire          reset,
    input wire [31:0]   paddr,
    input wire          psel,
    input wire          penable,
    input wire          pwrite,
    input wire [31:0]   pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    fb_port_if.bus      fb
);

    logic [31:0] pix_index;
    logic        in_range;
    logic        setup;
    // high in the first access cycle of a read
    logic        rd_wait;

    // word address, one pixel per 32-bit word
    assign pix_index = {2'b00, paddr[31:2]};
    assign in_range  = pix_index < 32'(FB_DEPTH);

    // setup phase of a transfer
    assign setup = psel && !penable;

    // memory access is issued during setup so the response
    // can come from registers in the access phase
    assign fb.addr    = pix_index[AW-1:0];
    assign fb.wr_data = pwdata[15:0];
    assign fb.wr_en   = setup && pwrite && in_range;
    assign fb.rd_en   = setup && !pwrite && in_range;

    always_ff @(posedge clk_pixel) begin
        if (reset) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            rd_wait <= 1'b0;
        end else begin
            // writes and bad addresses finish in the first access cycle,
            // reads one cycle later
            pready  <= (setup && (pwrite || !in_range)) || rd_wait;
            pslverr <= setup && !in_range;
            rd_wait <= setup && !pwrite && in_range;
        end
    end

    // memory data arrives in the first access cycle,
    // held on prdata for the second
    always_ff @(posedge clk_pixel) begin
        if (rd_wait) begin
            prdata <= {16'h0000, fb.rd_data};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/frame_buffer.sv ====
`default_nettype none

module frame_buffer #(
    parameter int FB_WIDTH  = video_pkg::DEF_FB_WIDTH,
    parameter int FB_HEIGHT = video_pkg::DEF_FB_HEIGHT,
    localparam int FB_DEPTH = FB_WIDTH * FB_HEIGHT,
    localparam int AW       = $clog2(FB_DEPTH)
) (
    input wire                 clk_pixel,
    fb_port_if.mem             fb,
    input wire [AW-1:0]        rd_addr,
    output video_pkg::rgb565_t rd_pixel
);

    // pixel index = y * FB_WIDTH + x
    video_pkg::rgb565_t mem [FB_DEPTH];

    // port a, bus side read and write
    always_ff @(posedge clk_pixel) begin
        if (fb.wr_en) begin
            mem[fb.addr] <= fb.wr_data;
        end
        if (fb.rd_en) begin
            fb.rd_data <= mem[fb.addr];
        end
    end

    // port b, display read with one cycle latency
    always_ff @(posedge clk_pixel) begin
        rd_pixel <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hdl/video_timing.sv ====
`default_nettype none

module video_timing #(
    parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT  = video_pkg::DEF_H_FRONT,
    parameter int H_SYNC   = video_pkg::DEF_H_SYNC,
    parameter int H_BACK   = video_pkg::DEF_H_BACK,
    parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT  = video_pkg::DEF_V_FRONT,
    parameter int V_SYNC   = video_pkg::DEF_V_SYNC,
    parameter int V_BACK   = video_pkg::DEF_V_BACK,
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK,
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK,
    localparam int H_W     = $clog2(H_TOTAL),
    localparam int V_W     = $clog2(V_TOTAL)
) (
    input wire         clk_pixel,
    input wire         reset,
    output logic [H_W-1:0] h_count,
    output logic [V_W-1:0] v_count,
    output logic       h_sync,
    output logic       v_sync,
    output logic       active
);

    // sync windows, end is exclusive
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    logic           line_end;
    logic           frame_end;
    logic [H_W-1:0] h_next;
    logic [V_W-1:0] v_next;

    assign line_end  = h_count == H_W'(H_TOTAL - 1);
    assign frame_end = v_count == V_W'(V_TOTAL - 1);

    // next raster position, forced to the origin by reset
    always_comb begin
        if (reset) begin
            h_next = '0;
            v_next = '0;
        end else begin
            h_next = line_end ? '0 : h_count + 1'b1;
            if (line_end) begin
                v_next = frame_end ? '0 : v_count + 1'b1;
            end else begin
                v_next = v_count;
            end
        end
    end

    // decode from the next position so the flags line up
    // with the counters in the same cycle
    always_ff @(posedge clk_pixel) begin
        h_count <= h_next;
        v_count <= v_next;
        h_sync  <= (h_next >= H_SYNC_START) && (h_next < H_SYNC_END);
        v_sync  <= (v_next >= V_SYNC_START) && (v_next < V_SYNC_END);
        active  <= (h_next < H_ACTIVE) && (v_next < V_ACTIVE);
    end

endmodule

`default_nettype wire

// ==== hdl/pixel_fetch.sv ====
`default_nettype none

module pixel_fetch #(
    parameter int FB_WIDTH  = video_pkg::DEF_FB_WIDTH,
    parameter int FB_HEIGHT = video_pkg::DEF_FB_HEIGHT,
    parameter int H_W       = 6,
    parameter int V_W       = 5,
    localparam int FB_DEPTH = FB_WIDTH * FB_HEIGHT,
    localparam int AW       = $clog2(FB_DEPTH)
) (
    input wire                clk_pixel,
    input wire                reset,
    input wire [H_W-1:0]      h_count,
    input wire [V_W-1:0]      v_count,
    input wire                h_sync,
    input wire                v_sync,
    input wire                active,
    output logic [AW-1:0]     rd_addr,
    input wire video_pkg::rgb565_t rd_pixel,
    video_beat_if.source      beat
);

    logic        in_window;
    logic [31:0] lin_index;
    // bit 1 is the stage that meets the memory data
    logic [1:0]  win_pipe;
    logic [1:0]  hs_pipe;
    logic [1:0]  vs_pipe;
    logic [1:0]  act_pipe;

    // window sits in the top left of the active area
    assign in_window = active && (h_count < FB_WIDTH) && (v_count < FB_HEIGHT);
    assign lin_index = 32'(v_count) * 32'(FB_WIDTH) + 32'(h_count);

    // stage 1, address register, memory adds stage 2
    always_ff @(posedge clk_pixel) begin
        rd_addr <= lin_index[AW-1:0];
    end

    // timing flags follow the address through both stages
    always_ff @(posedge clk_pixel) begin
        if (reset) begin
            win_pipe <= '0;
            hs_pipe  <= '0;
            vs_pipe  <= '0;
            act_pipe <= '0;
        end else begin
            win_pipe <= {win_pipe[0], in_window};
            hs_pipe  <= {hs_pipe[0], h_sync};
            vs_pipe  <= {vs_pipe[0], v_sync};
            act_pipe <= {act_pipe[0], active};
        end
    end

    assign beat.active = act_pipe[1];
    assign beat.h_sync = hs_pipe[1];
    assign beat.v_sync = vs_pipe[1];

    // 5:6:5 to 8:8:8 by zero fill of the low bits
    always_comb begin
        if (win_pipe[1]) begin
            beat.pixel.red   = {rd_pixel.red, 3'b000};
            beat.pixel.green = {rd_pixel.green, 2'b00};
            beat.pixel.blue  = {rd_pixel.blue, 3'b000};
        end else begin
            // outside the window
            beat.pixel = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tmds_encoder.sv ====
`default_nettype none

module tmds_encoder (
    input wire                    clk_pixel,
    input wire                    reset,
    video_beat_if.sink            beat,
    input wire [1:0]              channel,
    input wire video_pkg::ctrl_t  ctrl,
    output video_pkg::tmds_word_t tmds
);

    logic [7:0]            data;
    logic [3:0]            ones_d;
    logic                  use_xnor;
    logic [8:0]            q_m;
    logic [3:0]            ones_q;
    // ones minus zeros of q_m[7:0]
    logic signed [5:0]     balance;
    // running disparity, ones minus zeros sent so far
    logic signed [5:0]     disparity;
    logic signed [5:0]     disp_next;
    video_pkg::tmds_word_t data_word;
    video_pkg::tmds_word_t ctrl_word;

    // 0 red, 1 green, 2 blue
    always_comb begin
        case (channel)
            2'd0:    data = beat.pixel.red;
            2'd1:    data = beat.pixel.green;
            default: data = beat.pixel.blue;
        endcase
    end

    // stage one, minimise transitions
    always_comb begin
        ones_d   = 4'($countones(data));
        // xnor when ones dominate, tie broken by bit 0
        use_xnor = (ones_d > 4'd4) || ((ones_d == 4'd4) && !data[0]);
        q_m[0]   = data[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        end
        // bit 8 set for xor chaining
        q_m[8]   = !use_xnor;
        ones_q   = 4'($countones(q_m[7:0]));
        balance  = $signed({1'b0, ones_q, 1'b0}) - 6'sd8;
    end

    // stage two, dc balance
    always_comb begin
        if ((disparity == 0) || (balance == 0)) begin
            // no bias either way, invert only for xnor words
            data_word = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp_next = q_m[8] ? disparity + balance : disparity - balance;
        end else if (((disparity > 0) && (balance > 0)) ||
                     ((disparity < 0) && (balance < 0))) begin
            // word would push further the same way
            data_word = {1'b1, q_m[8], ~q_m[7:0]};
            disp_next = disparity - balance + (q_m[8] ? 6'sd2 : 6'sd0);
        end else begin
            data_word = {1'b0, q_m[8], q_m[7:0]};
            disp_next = disparity + balance - (q_m[8] ? 6'sd0 : 6'sd2);
        end
    end

    // blanking code from {vsync, hsync}
    always_comb begin
        case (ctrl)
            2'b00:   ctrl_word = video_pkg::CTRL_CODE_00;
            2'b01:   ctrl_word = video_pkg::CTRL_CODE_01;
            2'b10:   ctrl_word = video_pkg::CTRL_CODE_10;
            default: ctrl_word = video_pkg::CTRL_CODE_11;
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (reset) begin
            tmds      <= video_pkg::CTRL_CODE_00;
            disparity <= '0;
        end else if (beat.active) begin
            tmds      <= data_word;
            disparity <= disp_next;
        end else begin
            // disparity restarts at every active period
            tmds      <= ctrl_word;
            disparity <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/video_top.sv ====
`default_nettype none

module video_top (
    input wire                    clk_pixel,
    input wire                    reset,
    input wire [31:0]             paddr,
    input wire                    psel,
    input wire                    penable,
    input wire                    pwrite,
    input wire [31:0]             pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output video_pkg::tmds_word_t tmds_red,
    output video_pkg::tmds_word_t tmds_green,
    output video_pkg::tmds_word_t tmds_blue
);

    // raster and window from the package defaults
    localparam int H_ACTIVE  = video_pkg::DEF_H_ACTIVE;
    localparam int H_FRONT   = video_pkg::DEF_H_FRONT;
    localparam int H_SYNC    = video_pkg::DEF_H_SYNC;
    localparam int H_BACK    = video_pkg::DEF_H_BACK;
    localparam int V_ACTIVE  = video_pkg::DEF_V_ACTIVE;
    localparam int V_FRONT   = video_pkg::DEF_V_FRONT;
    localparam int V_SYNC    = video_pkg::DEF_V_SYNC;
    localparam int V_BACK    = video_pkg::DEF_V_BACK;
    localparam int FB_WIDTH  = video_pkg::DEF_FB_WIDTH;
    localparam int FB_HEIGHT = video_pkg::DEF_FB_HEIGHT;

    // counter and address widths, same rule as inside the modules
    localparam int H_W   = $clog2(H_ACTIVE + H_FRONT + H_SYNC + H_BACK);
    localparam int V_W   = $clog2(V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
    localparam int FB_AW = $clog2(FB_WIDTH * FB_HEIGHT);

    logic [H_W-1:0]     h_count;
    logic [V_W-1:0]     v_count;
    logic               h_sync;
    logic               v_sync;
    logic               active;
    logic [FB_AW-1:0]   rd_addr;
    video_pkg::rgb565_t rd_pixel;

    fb_port_if #(.ADDR_W(FB_AW)) u_fb_if ();
    video_beat_if u_beat ();

    // bus side
    apb_fb_port #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) u_apb_fb_port (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .fb        (u_fb_if.bus)
    );

    frame_buffer #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) u_frame_buffer (
        .clk_pixel (clk_pixel),
        .fb        (u_fb_if.mem),
        .rd_addr   (rd_addr),
        .rd_pixel  (rd_pixel)
    );

    // display side
    video_timing #(
        .H_ACTIVE  (H_ACTIVE),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_ACTIVE  (V_ACTIVE),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK)
    ) u_video_timing (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .h_count   (h_count),
        .v_count   (v_count),
        .h_sync    (h_sync),
        .v_sync    (v_sync),
        .active    (active)
    );

    pixel_fetch #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT),
        .H_W       (H_W),
        .V_W       (V_W)
    ) u_pixel_fetch (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .h_count   (h_count),
        .v_count   (v_count),
        .h_sync    (h_sync),
        .v_sync    (v_sync),
        .active    (active),
        .rd_addr   (rd_addr),
        .rd_pixel  (rd_pixel),
        .beat      (u_beat.source)
    );

    // red and green carry no sync
    tmds_encoder u_tmds_red (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .beat      (u_beat.sink),
        .channel   (2'd0),
        .ctrl      (2'b00),
        .tmds      (tmds_red)
    );

    tmds_encoder u_tmds_green (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .beat      (u_beat.sink),
        .channel   (2'd1),
        .ctrl      (2'b00),
        .tmds      (tmds_green)
    );

    // blue carries {vsync, hsync}
    tmds_encoder u_tmds_blue (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .beat      (u_beat.sink),
        .channel   (2'd2),
        .ctrl      ({u_beat.v_sync, u_beat.h_sync}),
        .tmds      (tmds_blue)
    );

endmodule

`default_nettype wire

// ==== dv/tb_video_top.sv ====
`default_nettype none

module tb_video_top;

    // raster and window sizes
    localparam int H_ACTIVE     = video_pkg::DEF_H_ACTIVE;
    localparam int H_TOTAL      = H_ACTIVE + video_pkg::DEF_H_FRONT
                                + video_pkg::DEF_H_SYNC + video_pkg::DEF_H_BACK;
    localparam int HS_START     = H_ACTIVE + video_pkg::DEF_H_FRONT;
    localparam int HS_END       = HS_START + video_pkg::DEF_H_SYNC;
    localparam int V_ACTIVE     = video_pkg::DEF_V_ACTIVE;
    localparam int V_TOTAL      = V_ACTIVE + video_pkg::DEF_V_FRONT
                                + video_pkg::DEF_V_SYNC + video_pkg::DEF_V_BACK;
    localparam int VS_START     = V_ACTIVE + video_pkg::DEF_V_FRONT;
    localparam int VS_END       = VS_START + video_pkg::DEF_V_SYNC;
    localparam int FB_W         = video_pkg::DEF_FB_WIDTH;
    localparam int FB_H         = video_pkg::DEF_FB_HEIGHT;
    localparam int FB_PIXELS    = FB_W * FB_H;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int CLK_PERIOD   = 8;

    // stimulus table, (x, y, pixel) rows
    localparam int N_ROWS = 8;
    localparam int N_ERR  = 4;
    int          row_x   [N_ROWS] = '{0, 31, 0, 31, 5, 17, 12, 30};
    int          row_y   [N_ROWS] = '{0, 0, 15, 15, 3, 9, 14, 1};
    logic [15:0] row_pix [N_ROWS] = '{16'hf800, 16'h07e0, 16'h001f, 16'hffff,
                                      16'h1234, 16'hbeef, 16'h0001, 16'h8410};
    // out of range byte addresses, 0x800 and 0x804 alias pixels 0 and 1
    logic [31:0] err_addr  [N_ERR] = '{32'h0000_0800, 32'h0000_0804,
                                       32'h8000_0000, 32'h0000_0ffc};
    logic        err_write [N_ERR] = '{1'b1, 1'b1, 1'b0, 1'b1};

    // watchdog budget, about 4 cycles per transfer plus three frames
    localparam int N_WRITES     = FB_PIXELS + N_ROWS + N_ERR;
    localparam int N_READS      = N_ROWS + N_ERR + 1;
    localparam int TIMEOUT_TIME = ((N_WRITES + N_READS) * 4 + 3 * FRAME_CYCLES)
                                * CLK_PERIOD + 1000;

    logic        clk_pixel;
    logic        reset;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [9:0]  tmds_red;
    logic [9:0]  tmds_green;
    logic [9:0]  tmds_blue;

    // copy of what the frame buffer should hold
    logic [15:0] model [FB_PIXELS];
    logic        loaded;
    logic        checking;
    logic        frame_done;
    int          pixels_checked;
    int unsigned seed_value;

    video_top u_dut (
        .clk_pixel  (clk_pixel),
        .reset      (reset),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .tmds_red   (tmds_red),
        .tmds_green (tmds_green),
        .tmds_blue  (tmds_blue)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #4 clk_pixel = ~clk_pixel;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: actual %h expected %h", name, actual, expected);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // standard TMDS data decode, undo inversion then xor or xnor chain
    function automatic logic [7:0] tmds_decode(input logic [9:0] word);
        logic [7:0] d;
        logic [7:0] q;
        d    = word[9] ? ~word[7:0] : word[7:0];
        q[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            q[i] = word[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
        end
        return q;
    endfunction

    // blanking words indexed by {vsync, hsync}
    function automatic logic [9:0] ctrl_code(input logic vs, input logic hs);
        case ({vs, hs})
            2'b00:   return 10'b1101010100;
            2'b01:   return 10'b0010101011;
            2'b10:   return 10'b0101010100;
            default: return 10'b1010101011;
        endcase
    endfunction

    // one APB transfer, checks wait states and pslverr
    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input logic [15:0] data, input logic exp_err,
                                output logic [31:0] rdata);
        int waits;
        int exp_waits;
        exp_waits = (write || exp_err) ? 0 : 1;
        @(posedge clk_pixel);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        // junk in the upper half, only the low 16 bits are stored
        pwdata  = {~data, data};
        @(posedge clk_pixel);
        #1;
        penable = 1'b1;
        waits   = 0;
        while (pready !== 1'b1) begin
            @(posedge clk_pixel);
            #1;
            waits++;
        end
        check_value("pready wait cycles", 32'(waits), 32'(exp_waits));
        check_value("pslverr", 32'(pslverr), 32'(exp_err));
        rdata = prdata;
        @(posedge clk_pixel);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    initial begin : main_seq
        logic [31:0] rdata;
        int          idx;
        seed_value     = $urandom(32'h1fd1);
        reset          = 1'b1;
        paddr          = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        pwdata         = '0;
        loaded         = 1'b0;
        checking       = 1'b0;
        frame_done     = 1'b0;
        pixels_checked = 0;
        // random background
        for (idx = 0; idx < FB_PIXELS; idx++) begin
            model[idx] = 16'($urandom());
        end
        repeat (4) @(posedge clk_pixel);
        #1;
        reset = 1'b0;
        // fill the whole frame buffer
        for (idx = 0; idx < FB_PIXELS; idx++) begin
            apb_transfer(1'b1, 32'(idx * 4), model[idx], 1'b0, rdata);
        end
        // table rows overwrite the background, write then read back
        for (idx = 0; idx < N_ROWS; idx++) begin
            apb_transfer(1'b1, 32'((row_y[idx] * FB_W + row_x[idx]) * 4), row_pix[idx],
                         1'b0, rdata);
            apb_transfer(1'b0, 32'((row_y[idx] * FB_W + row_x[idx]) * 4), 16'h0000,
                         1'b0, rdata);
            check_value("prdata", rdata, {16'h0000, row_pix[idx]});
            model[row_y[idx] * FB_W + row_x[idx]] = row_pix[idx];
        end
        for (idx = 0; idx < N_ERR; idx++) begin
            apb_transfer(err_write[idx], err_addr[idx], 16'hdead, 1'b1, rdata);
        end
        // pixel 0 must survive the aliased write
        apb_transfer(1'b0, 32'h0000_0000, 16'h0000, 1'b0, rdata);
        check_value("prdata", rdata, {16'h0000, model[0]});
        loaded = 1'b1;
        wait (frame_done);
        if (pixels_checked == FB_PIXELS) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("only %0d of %0d window pixels were checked", pixels_checked, FB_PIXELS);
            $display("Test failures found");
            $fatal(1);
        end
    end

    // output monitor, position of the word shown is 3 cycles behind the counters
    initial begin : monitor
        int          n;
        int          p;
        int          h;
        int          v;
        int          pos;
        logic        hs;
        logic        vs;
        logic [15:0] pix;
        n = 0;
        @(negedge reset);
        forever begin
            @(negedge clk_pixel);
            if (n < 3) begin
                check_value("tmds_red", 32'(tmds_red), 32'(ctrl_code(1'b0, 1'b0)));
                check_value("tmds_green", 32'(tmds_green), 32'(ctrl_code(1'b0, 1'b0)));
                check_value("tmds_blue", 32'(tmds_blue), 32'(ctrl_code(1'b0, 1'b0)));
            end else begin
                p   = n - 3;
                h   = p % H_TOTAL;
                v   = (p / H_TOTAL) % V_TOTAL;
                pos = p % FRAME_CYCLES;
                // full frame check starts on a frame boundary after loading
                if ((pos == 0) && loaded) begin
                    checking = 1'b1;
                end
                if ((h < H_ACTIVE) && (v < V_ACTIVE)) begin
                    if ((h < FB_W) && (v < FB_H)) begin
                        if (checking) begin
                            pix = model[v * FB_W + h];
                            check_value($sformatf("tmds_red at (%0d,%0d)", h, v),
                                        32'(tmds_decode(tmds_red)), 32'({pix[15:11], 3'b000}));
                            check_value($sformatf("tmds_green at (%0d,%0d)", h, v),
                                        32'(tmds_decode(tmds_green)), 32'({pix[10:5], 2'b00}));
                            check_value($sformatf("tmds_blue at (%0d,%0d)", h, v),
                                        32'(tmds_decode(tmds_blue)), 32'({pix[4:0], 3'b000}));
                            pixels_checked++;
                        end
                    end else begin
                        // black outside the window
                        check_value($sformatf("tmds_red at (%0d,%0d)", h, v),
                                    32'(tmds_decode(tmds_red)), 32'h0);
                        check_value($sformatf("tmds_green at (%0d,%0d)", h, v),
                                    32'(tmds_decode(tmds_green)), 32'h0);
                        check_value($sformatf("tmds_blue at (%0d,%0d)", h, v),
                                    32'(tmds_decode(tmds_blue)), 32'h0);
                    end
                end else begin
                    hs = (h >= HS_START) && (h < HS_END);
                    vs = (v >= VS_START) && (v < VS_END);
                    check_value($sformatf("tmds_red at (%0d,%0d)", h, v),
                                32'(tmds_red), 32'(ctrl_code(1'b0, 1'b0)));
                    check_value($sformatf("tmds_green at (%0d,%0d)", h, v),
                                32'(tmds_green), 32'(ctrl_code(1'b0, 1'b0)));
                    check_value($sformatf("tmds_blue at (%0d,%0d)", h, v),
                                32'(tmds_blue), 32'(ctrl_code(vs, hs)));
                end
                if ((pos == FRAME_CYCLES - 1) && checking) begin
                    checking   = 1'b0;
                    frame_done = 1'b1;
                end
            end
            n++;
        end
    end

    initial begin : watchdog
        #(TIMEOUT_TIME);
        $display("simulation timed out after %0d time units", TIMEOUT_TIME);
        $display("Test failures found");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/video_pkg.sv
hdl/fb_port_if.sv
hdl/video_beat_if.sv
hdl/apb_fb_port.sv
hdl/frame_buffer.sv
hdl/video_timing.sv
hdl/pixel_fetch.sv
hdl/tmds_encoder.sv
hdl/video_top.sv
dv/tb_video_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -f tb.f --top-module tb_video_top -o sim_tb; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
